// File: hw/arch_defs_pkg.sv
package arch_defs_pkg;

    // width of one SIMD lane
    localparam int DATA_WIDTH = 8;

    // a 32-bit bus word carries at most four lanes
    localparam int MAX_LANES = 4;

    // vector register file r0..r3
    localparam int NUM_REGS = 4;
    localparam int REG_IDX_WIDTH = $clog2(NUM_REGS);

    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_SUB = 2'b01,
        ALU_AND = 2'b10,
        ALU_OR  = 2'b11
    } alu_op_e;

    // zero sits in the top bit so lane k packs as zero, carry, negative
    typedef struct packed {
        logic zero;
        logic carry;
        logic negative;
    } alu_flags_t;

    // flag status word, one flag triple per possible lane
    localparam int STATUS_WIDTH = MAX_LANES * $bits(alu_flags_t);

    // register form, form bit is 0
    typedef struct packed {
        alu_op_e                  op;
        logic                     form;
        logic [REG_IDX_WIDTH-1:0] dst;
        logic [REG_IDX_WIDTH-1:0] src_a;
        logic [REG_IDX_WIDTH-1:0] src_b;
        logic [6:0]               spare;
    } instr_reg_t;

    // immediate form, form bit is 1, imm goes to every lane
    typedef struct packed {
        alu_op_e                  op;
        logic                     form;
        logic [REG_IDX_WIDTH-1:0] dst;
        logic [2:0]               spare;
        logic [DATA_WIDTH-1:0]    imm;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t reg_form;
        instr_imm_t imm_form;
    } instr_u;

endpackage

// File: hw/bus_defs_pkg.sv
package bus_defs_pkg;

    localparam int WB_DATA_WIDTH = 32;

    // word addresses, not byte addresses
    localparam int WB_ADDR_WIDTH = 3;

    // master to slave, Wishbone classic
    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [WB_ADDR_WIDTH-1:0] adr;
        logic [WB_DATA_WIDTH-1:0] dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic                     ack;
        logic [WB_DATA_WIDTH-1:0] dat;
    } wb_rsp_t;

    // instruction word, write only
    localparam logic [WB_ADDR_WIDTH-1:0] ADDR_INSTR = 3'd0;

    // packed lane flags, read only
    localparam logic [WB_ADDR_WIDTH-1:0] ADDR_STATUS = 3'd1;

    // r0..r3 at 4..7
    localparam logic [WB_ADDR_WIDTH-1:0] ADDR_REG_BASE = 3'd4;

endpackage

// File: hw/alu.sv
`timescale 1ns/10ps

module alu (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [arch_defs_pkg::DATA_WIDTH-1:0]  in_one_i,
    input  logic [arch_defs_pkg::DATA_WIDTH-1:0]  in_two_i,
    input  arch_defs_pkg::alu_op_e                alu_op_i,
    output logic [arch_defs_pkg::DATA_WIDTH-1:0]  latched_result_o,
    output arch_defs_pkg::alu_flags_t             flags_o
);

    // extra top bit holds the carry out
    logic [arch_defs_pkg::DATA_WIDTH:0]   arith_sum;
    logic [arch_defs_pkg::DATA_WIDTH-1:0] logic_res;
    logic [arch_defs_pkg::DATA_WIDTH-1:0] result;
    logic                                 carry_out;

    always_comb begin
        arith_sum = '0;
        logic_res = '0;
        result    = '0;
        carry_out = 1'b0;

        case (alu_op_i)
            arch_defs_pkg::ALU_ADD: arith_sum = {1'b0, in_one_i} + {1'b0, in_two_i};
            // a - b as a + ~b + 1
            arch_defs_pkg::ALU_SUB: arith_sum = {1'b0, in_one_i} + {1'b0, ~in_two_i}
                                              + {{arch_defs_pkg::DATA_WIDTH{1'b0}}, 1'b1};
            arch_defs_pkg::ALU_AND: logic_res = in_one_i & in_two_i;
            arch_defs_pkg::ALU_OR:  logic_res = in_one_i | in_two_i;
            default: ;
        endcase

        if (alu_op_i == arch_defs_pkg::ALU_ADD || alu_op_i == arch_defs_pkg::ALU_SUB) begin
            // for sub, carry set means no borrow
            carry_out = arith_sum[arch_defs_pkg::DATA_WIDTH];
            result    = arith_sum[arch_defs_pkg::DATA_WIDTH-1:0];
        end else begin
            carry_out = 1'b0;
            result    = logic_res;
        end
    end

    // flags follow the current operands, result shows up a cycle later
    assign flags_o = '{
        zero:     (result == '0),
        carry:    carry_out,
        negative: result[arch_defs_pkg::DATA_WIDTH-1]
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            latched_result_o <= '0;
        end else begin
            latched_result_o <= result;
        end
    end

endmodule

// File: hw/simd_issue.sv
`timescale 1ns/10ps

module simd_issue #(
    parameter int NUM_LANES = 4
) (
    input  logic                                                clk,
    input  logic                                                reset,
    input  bus_defs_pkg::wb_req_t                               wb_req_i,
    output bus_defs_pkg::wb_rsp_t                               wb_rsp_o,
    input  logic [arch_defs_pkg::STATUS_WIDTH-1:0]              status_i,
    input  logic                                                wb_valid_i,
    input  logic [arch_defs_pkg::REG_IDX_WIDTH-1:0]             wb_dst_i,
    input  logic [NUM_LANES-1:0][arch_defs_pkg::DATA_WIDTH-1:0] wb_data_i,
    output logic                                                issue_valid_o,
    output logic [arch_defs_pkg::REG_IDX_WIDTH-1:0]             issue_dst_o,
    output arch_defs_pkg::alu_op_e                              issue_op_o,
    output logic [NUM_LANES-1:0][arch_defs_pkg::DATA_WIDTH-1:0] operand_a_o,
    output logic [NUM_LANES-1:0][arch_defs_pkg::DATA_WIDTH-1:0] operand_b_o
);

    localparam int VEC_WIDTH = NUM_LANES * arch_defs_pkg::DATA_WIDTH;
    localparam int INSTR_WIDTH = $bits(arch_defs_pkg::instr_u);

    logic [NUM_LANES-1:0][arch_defs_pkg::DATA_WIDTH-1:0] regs_q [arch_defs_pkg::NUM_REGS];

    logic                                     sample;
    logic                                     host_reg_we;
    logic                                     instr_we;
    logic [bus_defs_pkg::WB_ADDR_WIDTH-1:0]   req_off;
    logic [bus_defs_pkg::WB_ADDR_WIDTH-1:0]   rd_off;
    logic                                     ack_q;
    logic [bus_defs_pkg::WB_ADDR_WIDTH-1:0]   rd_addr_q;
    logic [bus_defs_pkg::WB_DATA_WIDTH-1:0]   rd_data;
    arch_defs_pkg::instr_u                    instr_q;
    logic                                     instr_pending_q;
    logic [NUM_LANES-1:0][arch_defs_pkg::DATA_WIDTH-1:0] op_a;
    logic [NUM_LANES-1:0][arch_defs_pkg::DATA_WIDTH-1:0] op_b;

    // no new sample while ack is out, so a held stb is not taken twice
    assign sample      = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
    assign req_off     = wb_req_i.adr - bus_defs_pkg::ADDR_REG_BASE;
    assign host_reg_we = sample & wb_req_i.we & (wb_req_i.adr >= bus_defs_pkg::ADDR_REG_BASE);
    assign instr_we    = sample & wb_req_i.we & (wb_req_i.adr == bus_defs_pkg::ADDR_INSTR);

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q           <= 1'b0;
            rd_addr_q       <= '0;
            instr_pending_q <= 1'b0;
        end else begin
            ack_q           <= sample;
            instr_pending_q <= instr_we;
            if (sample) begin
                rd_addr_q <= wb_req_i.adr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instr_we) begin
            instr_q <= wb_req_i.dat[INSTR_WIDTH-1:0];
        end
    end

    // write-back goes last so it wins over a host write to the same register
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < arch_defs_pkg::NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            if (host_reg_we) begin
                regs_q[req_off[arch_defs_pkg::REG_IDX_WIDTH-1:0]] <= wb_req_i.dat[VEC_WIDTH-1:0];
            end
            if (wb_valid_i) begin
                regs_q[wb_dst_i] <= wb_data_i;
            end
        end
    end

    // form bit picks register sources or dst plus broadcast immediate
    always_comb begin
        if (instr_q.reg_form.form == 1'b0) begin
            op_a = regs_q[instr_q.reg_form.src_a];
            op_b = regs_q[instr_q.reg_form.src_b];
        end else begin
            op_a = regs_q[instr_q.imm_form.dst];
            op_b = {NUM_LANES{instr_q.imm_form.imm}};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid_o <= 1'b0;
            issue_dst_o   <= '0;
            issue_op_o    <= arch_defs_pkg::ALU_ADD;
            operand_a_o   <= '0;
            operand_b_o   <= '0;
        end else begin
            issue_valid_o <= instr_pending_q;
            if (instr_pending_q) begin
                issue_dst_o <= instr_q.reg_form.dst;
                issue_op_o  <= instr_q.reg_form.op;
                operand_a_o <= op_a;
                operand_b_o <= op_b;
            end
        end
    end

    // read data comes from the current state during the ack cycle
    assign rd_off = rd_addr_q - bus_defs_pkg::ADDR_REG_BASE;

    always_comb begin
        rd_data = '0;
        if (rd_addr_q == bus_defs_pkg::ADDR_STATUS) begin
            rd_data[arch_defs_pkg::STATUS_WIDTH-1:0] = status_i;
        end else if (rd_addr_q >= bus_defs_pkg::ADDR_REG_BASE) begin
            rd_data[VEC_WIDTH-1:0] = regs_q[rd_off[arch_defs_pkg::REG_IDX_WIDTH-1:0]];
        end
    end

    assign wb_rsp_o = '{ack: ack_q, dat: rd_data};

endmodule

// File: hw/simd_writeback.sv
`timescale 1ns/10ps

module simd_writeback #(
    parameter int NUM_LANES = 4
) (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic                                                issue_valid_i,
    input  logic [arch_defs_pkg::REG_IDX_WIDTH-1:0]             issue_dst_i,
    input  logic [NUM_LANES-1:0][arch_defs_pkg::DATA_WIDTH-1:0] lane_result_i,
    input  arch_defs_pkg::alu_flags_t [NUM_LANES-1:0]           lane_flags_i,
    output logic                                                wb_valid_o,
    output logic [arch_defs_pkg::REG_IDX_WIDTH-1:0]             wb_dst_o,
    output logic [NUM_LANES-1:0][arch_defs_pkg::DATA_WIDTH-1:0] wb_data_o,
    output logic [arch_defs_pkg::STATUS_WIDTH-1:0]              status_o
);

    localparam int FLAGS_WIDTH = NUM_LANES * $bits(arch_defs_pkg::alu_flags_t);

    logic                                           valid_q;
    logic [arch_defs_pkg::REG_IDX_WIDTH-1:0]        dst_q;
    arch_defs_pkg::alu_flags_t [NUM_LANES-1:0]      flags_q;
    logic [arch_defs_pkg::STATUS_WIDTH-1:0]         status_q;
    logic [arch_defs_pkg::STATUS_WIDTH-1:0]         status_next;

    // same stage as the lanes' latched result
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        dst_q   <= issue_dst_i;
        flags_q <= lane_flags_i;
    end

    // lane k lands in bits [3k+2:3k], missing lanes read zero
    always_comb begin
        status_next = '0;
        status_next[FLAGS_WIDTH-1:0] = flags_q;
    end

    // status keeps the last instruction's flags
    always_ff @(posedge clk) begin
        if (reset) begin
            status_q <= '0;
        end else if (valid_q) begin
            status_q <= status_next;
        end
    end

    assign wb_valid_o = valid_q;
    assign wb_dst_o   = dst_q;
    assign wb_data_o  = lane_result_i;
    assign status_o   = status_q;

endmodule

// File: hw/simd_alu_top.sv
`timescale 1ns/10ps

module simd_alu_top #(
    parameter int NUM_LANES = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  bus_defs_pkg::wb_req_t wb_req_i,
    output bus_defs_pkg::wb_rsp_t wb_rsp_o
);

    logic                                                issue_valid;
    logic [arch_defs_pkg::REG_IDX_WIDTH-1:0]             issue_dst;
    arch_defs_pkg::alu_op_e                              issue_op;
    logic [NUM_LANES-1:0][arch_defs_pkg::DATA_WIDTH-1:0] operand_a;
    logic [NUM_LANES-1:0][arch_defs_pkg::DATA_WIDTH-1:0] operand_b;
    logic [NUM_LANES-1:0][arch_defs_pkg::DATA_WIDTH-1:0] lane_result;
    arch_defs_pkg::alu_flags_t [NUM_LANES-1:0]           lane_flags;
    logic                                                wb_valid;
    logic [arch_defs_pkg::REG_IDX_WIDTH-1:0]             wb_dst;
    logic [NUM_LANES-1:0][arch_defs_pkg::DATA_WIDTH-1:0] wb_data;
    logic [arch_defs_pkg::STATUS_WIDTH-1:0]              status;

    simd_issue #(
        .NUM_LANES(NUM_LANES)
    ) u_issue (
        .clk           (clk),
        .reset         (reset),
        .wb_req_i      (wb_req_i),
        .wb_rsp_o      (wb_rsp_o),
        .status_i      (status),
        .wb_valid_i    (wb_valid),
        .wb_dst_i      (wb_dst),
        .wb_data_i     (wb_data),
        .issue_valid_o (issue_valid),
        .issue_dst_o   (issue_dst),
        .issue_op_o    (issue_op),
        .operand_a_o   (operand_a),
        .operand_b_o   (operand_b)
    );

    // one lane per byte, all sharing the opcode
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        alu u_alu (
            .clk              (clk),
            .reset            (reset),
            .in_one_i         (operand_a[g]),
            .in_two_i         (operand_b[g]),
            .alu_op_i         (issue_op),
            .latched_result_o (lane_result[g]),
            .flags_o          (lane_flags[g])
        );
    end

    simd_writeback #(
        .NUM_LANES(NUM_LANES)
    ) u_writeback (
        .clk           (clk),
        .reset         (reset),
        .issue_valid_i (issue_valid),
        .issue_dst_i   (issue_dst),
        .lane_result_i (lane_result),
        .lane_flags_i  (lane_flags),
        .wb_valid_o    (wb_valid),
        .wb_dst_o      (wb_dst),
        .wb_data_o     (wb_data),
        .status_o      (status)
    );

endmodule

// File: test/simd_alu_model.svh
`ifndef SIMD_ALU_MODEL_SVH
`define SIMD_ALU_MODEL_SVH

// lane count comes from the including module as NUM_LANES
logic [31:0] model_regs [4];
logic [31:0] model_status;

function automatic void clear_model();
    for (int i = 0; i < 4; i++) begin
        model_regs[i] = '0;
    end
    model_status = '0;
endfunction

// only the bytes that have a lane are kept
function automatic void store_host_write(input int idx, input logic [31:0] data);
    logic [31:0] kept;
    kept = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
        kept[8*k +: 8] = data[8*k +: 8];
    end
    model_regs[idx] = kept;
endfunction

// returns {zero, carry, negative, result}
function automatic logic [10:0] calc_lane(input arch_defs_pkg::alu_op_e op,
                                          input logic [7:0] a,
                                          input logic [7:0] b);
    logic [7:0] res;
    logic       carry;
    case (op)
        arch_defs_pkg::ALU_ADD: begin
            res   = a + b;
            carry = (int'(a) + int'(b)) > 255;
        end
        arch_defs_pkg::ALU_SUB: begin
            res   = a - b;
            // carry set means no borrow
            carry = (a >= b);
        end
        arch_defs_pkg::ALU_AND: begin
            res   = a & b;
            carry = 1'b0;
        end
        default: begin
            res   = a | b;
            carry = 1'b0;
        end
    endcase
    return {(res == 8'h00), carry, res[7], res};
endfunction

// immediate form uses dst as the first operand and imm in every lane
function automatic void apply_instr(input arch_defs_pkg::alu_op_e op, input logic use_imm,
                                    input logic [1:0] dst, input logic [1:0] src_a,
                                    input logic [1:0] src_b, input logic [7:0] imm);
    logic [31:0] vec_a;
    logic [31:0] vec_b;
    logic [31:0] result;
    logic [31:0] status;
    logic [10:0] lane;
    vec_a  = use_imm ? model_regs[dst] : model_regs[src_a];
    vec_b  = use_imm ? {4{imm}} : model_regs[src_b];
    result = '0;
    status = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
        lane               = calc_lane(op, vec_a[8*k +: 8], vec_b[8*k +: 8]);
        result[8*k +: 8]   = lane[7:0];
        status[3*k +: 3]   = lane[10:8];
    end
    model_regs[dst] = result;
    model_status    = status;
endfunction

`endif

// File: test/tb_simd_alu.sv
`timescale 1ns/10ps

module tb_simd_alu;

    localparam int NUM_LANES        = 4;
    localparam int CLK_PERIOD       = 100;
    localparam int DRIVE_DELAY      = 5;
    localparam int RESET_CYCLES     = 4;
    localparam int NUM_INSTR        = 300;
    localparam int CYCLES_PER_INSTR = 20;
    localparam int ACK_LIMIT        = 4;
    localparam int REG_WRITES       = 40;

    // instruction mix adds up to NUM_INSTR
    localparam int ARITH_COUNT = 80;
    localparam int LOGIC_COUNT = 80;
    localparam int IMM_COUNT   = 80;
    localparam int CHAIN_COUNT = 60;

    logic                  clk;
    logic                  reset;
    bus_defs_pkg::wb_req_t wb_req;
    bus_defs_pkg::wb_rsp_t wb_rsp;

    `include "simd_alu_model.svh"

    simd_alu_top #(
        .NUM_LANES(NUM_LANES)
    ) UUT (
        .clk      (clk),
        .reset    (reset),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #((RESET_CYCLES + NUM_INSTR * CYCLES_PER_INSTR) * CLK_PERIOD);
        $display("Run did not finish within the expected time, stopped by the watchdog");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        assert (got === expected) else begin
            $display("Mismatch on %s: expected 0x%08h, got 0x%08h", name, expected, got);
            $display("Test failed");
            $fatal(1, "value check failed");
        end
    endtask

    // ack must show up in the cycle right after the request is sampled
    task automatic wait_for_ack();
        int   cycles;
        logic got_ack;
        cycles  = 0;
        got_ack = 1'b0;
        while (!got_ack && cycles < ACK_LIMIT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
            got_ack = wb_rsp.ack;
        end
        assert (got_ack) else begin
            $display("No ack from the DUT within %0d cycles of the request", ACK_LIMIT);
            $display("Test failed");
            $fatal(1, "missing ack");
        end
        check_word("wb_rsp.ack latency in cycles", cycles, 32'd1);
    endtask

    // stb drops in the ack cycle and one idle cycle follows
    task automatic wb_write(input logic [2:0] adr, input logic [31:0] dat);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b1;
        wb_req.adr = adr;
        wb_req.dat = dat;
        wait_for_ack();
        wb_req = '0;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [31:0] dat);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b0;
        wb_req.adr = adr;
        wb_req.dat = '0;
        wait_for_ack();
        dat    = wb_rsp.dat;
        wb_req = '0;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    function automatic logic [2:0] reg_addr(input int idx);
        return bus_defs_pkg::ADDR_REG_BASE + 3'(idx);
    endfunction

    task automatic write_reg(input int idx, input logic [31:0] data);
        wb_write(reg_addr(idx), data);
        store_host_write(idx, data);
    endtask

    task automatic check_reg(input int idx);
        logic [31:0] got;
        wb_read(reg_addr(idx), got);
        check_word($sformatf("wb_rsp.dat (r%0d)", idx), got, model_regs[idx]);
    endtask

    task automatic check_status(output logic [31:0] word);
        wb_read(bus_defs_pkg::ADDR_STATUS, word);
        check_word("wb_rsp.dat (status)", word, model_status);
    endtask

    task automatic issue_instr(input arch_defs_pkg::alu_op_e op, input logic use_imm,
                               input logic [1:0] dst, input logic [1:0] src_a,
                               input logic [1:0] src_b, input logic [7:0] imm);
        arch_defs_pkg::instr_u instr;
        instr = '0;
        if (use_imm) begin
            instr.imm_form.op   = op;
            instr.imm_form.form = 1'b1;
            instr.imm_form.dst  = dst;
            instr.imm_form.imm  = imm;
        end else begin
            instr.reg_form.op    = op;
            instr.reg_form.form  = 1'b0;
            instr.reg_form.dst   = dst;
            instr.reg_form.src_a = src_a;
            instr.reg_form.src_b = src_b;
        end
        wb_write(bus_defs_pkg::ADDR_INSTR, {16'h0000, instr});
        apply_instr(op, use_imm, dst, src_a, src_b, imm);
        // result lands at the end of the second cycle after the ack
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    initial begin
        logic [31:0]            data;
        logic [31:0]            status_word;
        logic [1:0]             dst;
        logic [1:0]             src_a;
        logic [1:0]             src_b;
        logic [7:0]             imm;
        logic                   use_imm;
        arch_defs_pkg::alu_op_e op;

        void'($urandom(7));
        reset  = 1'b1;
        wb_req = '0;
        clear_model();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        // everything reads zero after reset
        for (int i = 0; i < 4; i++) begin
            check_reg(i);
        end
        check_status(status_word);
        wb_read(bus_defs_pkg::ADDR_INSTR, data);
        check_word("wb_rsp.dat (instr address)", data, 32'h0);
        // status ignores host writes
        wb_write(bus_defs_pkg::ADDR_STATUS, $urandom());
        check_status(status_word);

        for (int n = 0; n < REG_WRITES; n++) begin
            dst = $urandom_range(3, 0);
            write_reg(dst, $urandom());
            check_reg(dst);
        end

        // ADD and SUB in register form
        for (int n = 0; n < ARITH_COUNT; n++) begin
            write_reg($urandom_range(3, 0), $urandom());
            op    = ($urandom_range(1, 0) == 0) ? arch_defs_pkg::ALU_ADD : arch_defs_pkg::ALU_SUB;
            dst   = $urandom_range(3, 0);
            src_a = $urandom_range(3, 0);
            src_b = $urandom_range(3, 0);
            issue_instr(op, 1'b0, dst, src_a, src_b, 8'h00);
            check_reg(dst);
            check_status(status_word);
        end

        for (int n = 0; n < LOGIC_COUNT; n++) begin
            write_reg($urandom_range(3, 0), $urandom());
            op    = ($urandom_range(1, 0) == 0) ? arch_defs_pkg::ALU_AND : arch_defs_pkg::ALU_OR;
            dst   = $urandom_range(3, 0);
            src_a = $urandom_range(3, 0);
            src_b = $urandom_range(3, 0);
            issue_instr(op, 1'b0, dst, src_a, src_b, 8'h00);
            check_reg(dst);
            check_status(status_word);
        end

        // immediate form with imm broadcast to all lanes
        for (int n = 0; n < IMM_COUNT; n++) begin
            write_reg($urandom_range(3, 0), $urandom());
            op  = arch_defs_pkg::alu_op_e'($urandom_range(3, 0));
            dst = $urandom_range(3, 0);
            imm = $urandom_range(255, 0);
            issue_instr(op, 1'b1, dst, 2'd0, 2'd0, imm);
            check_reg(dst);
            check_status(status_word);
        end

        // dependent chain where dst is always a source
        for (int n = 0; n < CHAIN_COUNT; n++) begin
            op      = arch_defs_pkg::alu_op_e'($urandom_range(3, 0));
            dst     = $urandom_range(3, 0);
            src_b   = $urandom_range(3, 0);
            use_imm = $urandom_range(1, 0);
            imm     = $urandom_range(255, 0);
            issue_instr(op, use_imm, dst, dst, src_b, imm);
            if ($urandom_range(1, 0) == 1) begin
                // sampled in the write-back cycle so the ALU result is kept
                wb_write(reg_addr(dst), $urandom());
            end
            check_reg(dst);
            check_status(status_word);
        end

        $display("Test passed");
        $finish;
    end

endmodule

// File: sim.f
+incdir+test
hw/arch_defs_pkg.sv
hw/bus_defs_pkg.sv
hw/alu.sv
hw/simd_issue.sv
hw/simd_writeback.sv
hw/simd_alu_top.sv
test/tb_simd_alu.sv

// File: Bender.yml
package:
  name: simd_alu

sources:
  - files:
      - hw/arch_defs_pkg.sv
      - hw/bus_defs_pkg.sv
      - hw/alu.sv
      - hw/simd_issue.sv
      - hw/simd_writeback.sv
      - hw/simd_alu_top.sv

  - target: test
    include_dirs:
      - test
    files:
      - test/tb_simd_alu.sv
